// ==== logic/tag_dir_pkg.sv ====
`default_nettype none

package tag_dir_pkg;

    localparam int num_entries = 4;
    localparam int tag_w       = 2;
    localparam int index_w     = 4;
    // list length runs 0 to num_entries
    localparam int count_w     = 3;

    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [count_w-1:0] count_t;

    typedef enum logic [2:0] {
        cmd_lookup     = 3'd0,
        cmd_write      = 3'd1,
        cmd_alloc      = 3'd2,
        cmd_fill_clean = 3'd3,
        cmd_fill_dirty = 3'd4
    } cmd_e;

    typedef enum logic [1:0] {
        st_invalid = 2'd0,
        st_filling = 2'd1,
        st_clean   = 2'd2,
        st_dirty   = 2'd3
    } line_state_e;

    typedef struct packed {
        cmd_e   cmd;
        index_t index;
        tag_t   tag;
    } dir_req_t;

    // state and index are the values before the request
    typedef struct packed {
        logic        hit;
        logic        refused;
        tag_t        tag;
        line_state_e state;
        index_t      index;
    } dir_rsp_t;

    typedef struct packed {
        logic        touch;
        logic        take_free;
        logic        evict;
        logic        set_state;
        line_state_e new_state;
        tag_t        tag;
    } entry_op_t;

endpackage

`default_nettype wire

// ==== logic/access_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module access_ctrl (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    req_valid,
    input  tag_dir_pkg::dir_req_t                                   req,
    input  logic                                                    match_hit,
    input  tag_dir_pkg::tag_t                                       match_tag,
    input  tag_dir_pkg::line_state_e [tag_dir_pkg::num_entries-1:0] entry_state,
    input  tag_dir_pkg::index_t [tag_dir_pkg::num_entries-1:0]      entry_index,
    input  logic                                                    free_empty,
    input  tag_dir_pkg::tag_t                                       free_tail,
    input  tag_dir_pkg::tag_t                                       lru_tail,
    output logic                                                    op_valid,
    output tag_dir_pkg::entry_op_t                                  op,
    output tag_dir_pkg::index_t                                     alloc_index,
    output logic                                                    rsp_valid,
    output tag_dir_pkg::dir_rsp_t                                   rsp
);

    tag_dir_pkg::dir_rsp_t    rsp_d;
    tag_dir_pkg::tag_t        act_tag;
    tag_dir_pkg::line_state_e act_state;
    logic                     act_known;
    logic                     index_cmd;
    logic                     refused;
    logic                     victim_busy;

    // lru tail still waiting for its fill cannot be replaced
    assign victim_busy = free_empty && (entry_state[lru_tail] == tag_dir_pkg::st_filling);
    assign alloc_index = req.index;

    always_comb begin
        op        = '0;
        act_tag   = match_tag;
        act_known = match_hit;
        index_cmd = 1'b1;
        refused   = 1'b0;
        case (req.cmd)
            tag_dir_pkg::cmd_lookup: begin
                op.touch = match_hit;
                op.tag   = match_tag;
            end
            tag_dir_pkg::cmd_write: begin
                op.touch = match_hit;
                op.tag   = match_tag;
                if (match_hit && entry_state[match_tag] == tag_dir_pkg::st_clean) begin
                    op.set_state = 1'b1;
                    op.new_state = tag_dir_pkg::st_dirty;
                end
            end
            tag_dir_pkg::cmd_alloc: begin
                act_known = 1'b1;
                if (match_hit) begin
                    // already present, same as a lookup
                    op.touch = 1'b1;
                    op.tag   = match_tag;
                end else if (!free_empty) begin
                    op.take_free = 1'b1;
                    op.tag       = free_tail;
                    act_tag      = free_tail;
                end else if (victim_busy) begin
                    refused = 1'b1;
                    act_tag = lru_tail;
                end else begin
                    op.evict = 1'b1;
                    op.tag   = lru_tail;
                    act_tag  = lru_tail;
                end
            end
            tag_dir_pkg::cmd_fill_clean, tag_dir_pkg::cmd_fill_dirty: begin
                // named by tag, no recency update
                index_cmd = 1'b0;
                act_known = 1'b1;
                act_tag   = req.tag;
                op.tag    = req.tag;
                if (entry_state[req.tag] == tag_dir_pkg::st_filling) begin
                    op.set_state = 1'b1;
                    op.new_state = (req.cmd == tag_dir_pkg::cmd_fill_clean) ?
                                   tag_dir_pkg::st_clean : tag_dir_pkg::st_dirty;
                end
            end
            default: begin
                index_cmd = 1'b0;
                act_known = 1'b0;
            end
        endcase
    end

    assign op_valid  = req_valid && (op.touch || op.take_free || op.evict || op.set_state);
    assign act_state = entry_state[act_tag];

    // misses report zeros, invalid entries carry no index
    always_comb begin
        rsp_d.hit     = index_cmd && match_hit;
        rsp_d.refused = refused;
        rsp_d.tag     = act_known ? act_tag : '0;
        rsp_d.state   = act_known ? act_state : tag_dir_pkg::st_invalid;
        rsp_d.index   = (act_known && act_state != tag_dir_pkg::st_invalid) ?
                        entry_index[act_tag] : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp <= rsp_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_store (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    op_valid,
    input  tag_dir_pkg::entry_op_t                                  op,
    input  tag_dir_pkg::index_t                                     alloc_index,
    input  tag_dir_pkg::index_t                                     lookup_index,
    output logic                                                    match_hit,
    output tag_dir_pkg::tag_t                                       match_tag,
    output tag_dir_pkg::line_state_e [tag_dir_pkg::num_entries-1:0] entry_state,
    output tag_dir_pkg::index_t [tag_dir_pkg::num_entries-1:0]      entry_index
);

    tag_dir_pkg::line_state_e [tag_dir_pkg::num_entries-1:0] state_q;
    tag_dir_pkg::index_t [tag_dir_pkg::num_entries-1:0]      index_q;
    logic [tag_dir_pkg::num_entries-1:0]                     row_match;
    logic                                                    alloc;

    // free take and eviction both load a new line
    assign alloc = op_valid && (op.take_free || op.evict);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < tag_dir_pkg::num_entries; i++) begin
                state_q[i] <= tag_dir_pkg::st_invalid;
            end
        end else if (alloc) begin
            state_q[op.tag] <= tag_dir_pkg::st_filling;
        end else if (op_valid && op.set_state) begin
            state_q[op.tag] <= op.new_state;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            index_q[op.tag] <= alloc_index;
        end
    end

    // parallel compare, invalid rows never match
    always_comb begin
        for (int i = 0; i < tag_dir_pkg::num_entries; i++) begin
            row_match[i] = (state_q[i] != tag_dir_pkg::st_invalid) &&
                           (index_q[i] == lookup_index);
        end
    end

    // at most one row holds a given index
    always_comb begin
        match_hit = 1'b0;
        match_tag = '0;
        for (int i = 0; i < tag_dir_pkg::num_entries; i++) begin
            if (row_match[i]) begin
                match_hit = 1'b1;
                match_tag = tag_dir_pkg::tag_t'(i);
            end
        end
    end

    assign entry_state = state_q;
    assign entry_index = index_q;

endmodule

`default_nettype wire

// ==== logic/recency_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module recency_list (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   op_valid,
    input  tag_dir_pkg::entry_op_t op,
    output logic                   free_empty,
    output tag_dir_pkg::tag_t      free_tail,
    output tag_dir_pkg::tag_t      lru_tail
);

    typedef struct packed {
        tag_dir_pkg::tag_t   head;
        tag_dir_pkg::tag_t   tail;
        tag_dir_pkg::count_t len;
    } list_t;

    list_t free_q;
    list_t free_d;
    list_t lru_q;
    list_t lru_d;
    list_t src;

    // one prev/next pair per entry, shared by both lists
    tag_dir_pkg::tag_t [tag_dir_pkg::num_entries-1:0] prv_q;
    tag_dir_pkg::tag_t [tag_dir_pkg::num_entries-1:0] prv_d;
    tag_dir_pkg::tag_t [tag_dir_pkg::num_entries-1:0] nxt_q;
    tag_dir_pkg::tag_t [tag_dir_pkg::num_entries-1:0] nxt_d;

    tag_dir_pkg::tag_t node;
    logic              move;

    assign node = op.tag;
    assign move = op_valid && (op.take_free || op.evict || op.touch);

    always_comb begin
        free_d = free_q;
        lru_d  = lru_q;
        prv_d  = prv_q;
        nxt_d  = nxt_q;
        src    = op.take_free ? free_q : lru_q;
        if (move) begin
            // unlink from the list that holds the node
            if (node == src.head) begin
                src.head = nxt_q[node];
            end else begin
                nxt_d[prv_q[node]] = nxt_q[node];
            end
            if (node == src.tail) begin
                src.tail = prv_q[node];
            end else begin
                prv_d[nxt_q[node]] = prv_q[node];
            end
            src.len = src.len - tag_dir_pkg::count_t'(1);
            if (op.take_free) begin
                free_d = src;
            end else begin
                lru_d = src;
            end

            // push at the mru end; later writes win over the splice above
            if (lru_d.len == '0) begin
                lru_d.tail = node;
            end else begin
                nxt_d[node]       = lru_d.head;
                prv_d[lru_d.head] = node;
            end
            lru_d.head = node;
            lru_d.len  = lru_d.len + tag_dir_pkg::count_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // free list 0 .. n-1, taken from the high end
            free_q.head <= '0;
            free_q.tail <= tag_dir_pkg::tag_t'(tag_dir_pkg::num_entries - 1);
            free_q.len  <= tag_dir_pkg::count_t'(tag_dir_pkg::num_entries);
            lru_q       <= '0;
            for (int i = 0; i < tag_dir_pkg::num_entries; i++) begin
                prv_q[i] <= tag_dir_pkg::tag_t'(i - 1);
                nxt_q[i] <= tag_dir_pkg::tag_t'(i + 1);
            end
        end else begin
            free_q <= free_d;
            lru_q  <= lru_d;
            prv_q  <= prv_d;
            nxt_q  <= nxt_d;
        end
    end

    assign free_empty = (free_q.len == '0);
    assign free_tail  = free_q.tail;
    assign lru_tail   = lru_q.tail;

endmodule

`default_nettype wire

// ==== logic/tag_dir_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_dir_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  tag_dir_pkg::dir_req_t req,
    output logic                  rsp_valid,
    output tag_dir_pkg::dir_rsp_t rsp
);

    logic                                                    match_hit;
    tag_dir_pkg::tag_t                                       match_tag;
    tag_dir_pkg::line_state_e [tag_dir_pkg::num_entries-1:0] entry_state;
    tag_dir_pkg::index_t [tag_dir_pkg::num_entries-1:0]      entry_index;

    logic              free_empty;
    tag_dir_pkg::tag_t free_tail;
    tag_dir_pkg::tag_t lru_tail;

    logic                   op_valid;
    tag_dir_pkg::entry_op_t op;
    tag_dir_pkg::index_t    alloc_index;

    access_ctrl u_access_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .match_hit   (match_hit),
        .match_tag   (match_tag),
        .entry_state (entry_state),
        .entry_index (entry_index),
        .free_empty  (free_empty),
        .free_tail   (free_tail),
        .lru_tail    (lru_tail),
        .op_valid    (op_valid),
        .op          (op),
        .alloc_index (alloc_index),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

    // match runs on the raw request index
    tag_store u_tag_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_valid     (op_valid),
        .op           (op),
        .alloc_index  (alloc_index),
        .lookup_index (req.index),
        .match_hit    (match_hit),
        .match_tag    (match_tag),
        .entry_state  (entry_state),
        .entry_index  (entry_index)
    );

    recency_list u_recency_list (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .op         (op),
        .free_empty (free_empty),
        .free_tail  (free_tail),
        .lru_tail   (lru_tail)
    );

endmodule

`default_nettype wire

// ==== bench/tag_dir_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_dir_tb;

    localparam int rsp_timeout = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    tag_dir_pkg::dir_req_t req;
    logic                  rsp_valid;
    tag_dir_pkg::dir_rsp_t rsp;

    int    fd;
    int    n_fields;
    int    tests_run;
    int    tests_failed;
    int    errors;
    logic  timed_out;
    string line;

    // fields of the current data line
    logic [2:0] cmd_v;
    logic [3:0] index_v;
    logic [1:0] tag_v;
    logic       exp_hit;
    logic       exp_refused;
    logic [1:0] exp_tag;
    logic [1:0] exp_state;
    logic [3:0] exp_index;

    tag_dir_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #4 clk = ~clk;

    task automatic compare_field(input string name, input logic [3:0] got,
                                 input logic [3:0] exp, inout int mismatches);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    // one-cycle strobe just after the edge
    task automatic send_request(inout int mismatches);
        @(posedge clk);
        #1;
        // previous response pulse must be over by now
        compare_field("rsp_valid", 4'(rsp_valid), 4'h0, mismatches);
        req_valid = 1'b1;
        req.cmd   = tag_dir_pkg::cmd_e'(cmd_v);
        req.index = index_v;
        req.tag   = tag_v;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic await_response(output logic seen, output int waited);
        int cycles;
        cycles = 0;
        while (!rsp_valid && cycles < rsp_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        seen   = rsp_valid;
        waited = cycles;
    endtask

    task automatic run_test();
        logic seen;
        int   waited;
        int   mismatches;
        mismatches = 0;
        tests_run++;
        send_request(mismatches);
        await_response(seen, waited);
        if (!seen) begin
            $display("test %0d: no response within %0d cycles", tests_run, rsp_timeout);
            timed_out = 1'b1;
            tests_failed++;
        end else begin
            // response is due one cycle after the strobe
            assert (waited == 0) else begin
                $display("test %0d: response came %0d cycles late", tests_run, waited);
                mismatches++;
            end
            compare_field("rsp.hit", 4'(rsp.hit), 4'(exp_hit), mismatches);
            compare_field("rsp.refused", 4'(rsp.refused), 4'(exp_refused), mismatches);
            compare_field("rsp.tag", 4'(rsp.tag), 4'(exp_tag), mismatches);
            compare_field("rsp.state", 4'(rsp.state), 4'(exp_state), mismatches);
            compare_field("rsp.index", rsp.index, exp_index, mismatches);
            if (mismatches == 0) begin
                $display("test %0d: cmd %0d index %h tag %h ok",
                         tests_run, cmd_v, index_v, tag_v);
            end else begin
                $display("test %0d: cmd %0d index %h tag %h failed, %0d fields wrong",
                         tests_run, cmd_v, index_v, tag_v, mismatches);
                tests_failed++;
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        tests_run    = 0;
        tests_failed = 0;
        errors       = 0;
        timed_out    = 1'b0;

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fd = $fopen("bench/tag_dir_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/tag_dir_tests.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                   cmd_v, index_v, tag_v, exp_hit, exp_refused,
                                   exp_tag, exp_state, exp_index);
                // comment and blank lines do not scan
                if (n_fields == 8) begin
                    run_test();
                end
            end
            $fclose(fd);
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (errors == 0 && tests_failed == 0 && tests_run > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tag_dir_tests.txt ====
# cmd index tag, then expected hit refused tag state index (all hex)
# cmd 0 lookup 1 write 2 alloc 3 fill clean 4 fill dirty, state 0 inv 1 fill 2 clean 3 dirty
2 5 0 0 0 3 0 0
2 6 0 0 0 2 0 0
2 7 0 0 0 1 0 0
2 8 0 0 0 0 0 0
0 5 0 1 0 3 1 5
0 6 0 1 0 2 1 6
0 7 0 1 0 1 1 7
0 8 0 1 0 0 1 8
0 9 0 0 0 0 0 0
3 0 3 0 0 3 1 5
4 0 2 0 0 2 1 6
0 5 0 1 0 3 2 5
0 6 0 1 0 2 3 6
1 5 0 1 0 3 2 5
0 5 0 1 0 3 3 5
1 6 0 1 0 2 3 6
1 a 0 0 0 0 0 0
3 0 3 0 0 3 3 5
3 0 1 0 0 1 1 7
3 0 0 0 0 0 1 8
0 8 0 1 0 0 2 8
0 7 0 1 0 1 2 7
0 5 0 1 0 3 3 5
0 6 0 1 0 2 3 6
2 b 0 0 0 0 2 8
0 8 0 0 0 0 0 0
2 c 0 0 0 1 2 7
2 d 0 0 0 3 3 5
2 e 0 0 0 2 3 6
2 f 0 0 1 0 1 b
0 f 0 0 0 0 0 0
2 f 0 0 1 0 1 b
3 0 0 0 0 0 1 b
3 0 1 0 0 1 1 c
3 0 2 0 0 2 1 e
4 0 3 0 0 3 1 d
2 b 0 1 0 0 2 b
2 1 0 0 0 1 2 c
2 2 0 0 0 3 3 d
0 b 0 1 0 0 2 b
2 3 0 0 0 2 2 e
0 1 0 1 0 1 1 1

// ==== list.f ====
logic/tag_dir_pkg.sv
logic/access_ctrl.sv
logic/tag_store.sv
logic/recency_list.sv
logic/tag_dir_top.sv
bench/tag_dir_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tag_dir_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
SEED      ?= 34716
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(SIM) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
